//--- logic/rs_pkg.sv
package rs_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   // datapath width
   localparam int XLEN = 32;
   // architectural register file
   localparam int NUM_REGS = 32;
   localparam int REG_W = 5;
   // rob tag, 8 entries
   localparam int TAG_W = 3;
   // one station per unit
   localparam int NUM_STATIONS = 5;

   //////////////////////////////////////////////////////////////////////
   // encodings
   //////////////////////////////////////////////////////////////////////

   // station index, also the unit index on exec_busy / exec_run
   typedef enum logic [2:0] {
      FU_ALU    = 3'd0,
      FU_LSU    = 3'd1,
      FU_BRANCH = 3'd2,
      FU_MUL0   = 3'd3,
      FU_MUL1   = 3'd4
   } fu_kind_t;

   // dispatch opcode, picks the station
   typedef enum logic [1:0] {
      OP_ALU    = 2'd0,
      OP_MEM    = 2'd1,
      OP_BRANCH = 2'd2,
      OP_MUL    = 2'd3
   } op_kind_t;

   //////////////////////////////////////////////////////////////////////
   // packets
   //////////////////////////////////////////////////////////////////////

   // rename map entry
   typedef struct packed {
      logic             pending;
      logic [TAG_W-1:0] tag;
      logic             ready;
   } map_entry_t;

   // one instruction from dispatch
   typedef struct packed {
      op_kind_t         op;
      logic [TAG_W-1:0] tag;
      logic [REG_W-1:0] src1;
      logic [REG_W-1:0] src2;
      logic [REG_W-1:0] dest;
      // values read by the caller from regfile or rob
      logic [XLEN-1:0]  value1;
      logic [XLEN-1:0]  value2;
   } dispatch_t;

   // common data bus broadcast
   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  value;
   } cdb_t;

   // retire event from the rob head
   typedef struct packed {
      logic             valid;
      logic [REG_W-1:0] arch_reg;
      logic [TAG_W-1:0] tag;
   } retire_t;

   // station to unit
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  value1;
      logic [XLEN-1:0]  value2;
   } issue_t;

   // one source operand held in a station
   typedef struct packed {
      logic [TAG_W-1:0] wait_tag;
      logic             ready;
      logic [XLEN-1:0]  value;
   } operand_t;

   // full station contents
   typedef struct packed {
      logic             occupied;
      logic [TAG_W-1:0] tag;
      operand_t         opnd1;
      operand_t         opnd2;
   } station_t;

endpackage

//--- logic/rename_map.sv
`timescale 1ns/100ps

module rename_map (
   input  logic               clock,
   input  logic               reset,
   input  logic               accept,
   input  rs_pkg::dispatch_t  dispatch,
   input  rs_pkg::cdb_t       cdb,
   input  rs_pkg::retire_t    retire,
   output rs_pkg::map_entry_t src1_state,
   output rs_pkg::map_entry_t src2_state
);

   // one entry per architectural register
   rs_pkg::map_entry_t map [rs_pkg::NUM_REGS];

   // rename write for this edge
   logic rename_en;

   //////////////////////////////////////////////////////////////////////
   // lookup
   //////////////////////////////////////////////////////////////////////

   // combinational read of the registered map
   // a rename at this edge shows up next cycle
   always_comb begin
      src1_state = map[dispatch.src1];
      src2_state = map[dispatch.src2];
      // r0 never has a producer
      if (dispatch.src1 == '0) begin
         src1_state = '0;
      end
      if (dispatch.src2 == '0) begin
         src2_state = '0;
      end
   end

   // r0 is never renamed
   assign rename_en = accept && (dispatch.dest != '0);

   //////////////////////////////////////////////////////////////////////
   // update
   //////////////////////////////////////////////////////////////////////

   // order below sets priority, last write wins
   //   cdb mark, then retire clear, then rename
   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < rs_pkg::NUM_REGS; i++) begin
            map[i] <= '0;
         end
      end else begin
         // wake-up, any pending entry with the broadcast tag
         if (cdb.valid) begin
            for (int i = 0; i < rs_pkg::NUM_REGS; i++) begin
               if (map[i].pending && (map[i].tag == cdb.tag)) begin
                  map[i].ready <= 1'b1;
               end
            end
         end

         // retire clears only if no younger producer took the register
         if (retire.valid) begin
            if (map[retire.arch_reg].pending &&
                (map[retire.arch_reg].tag == retire.tag)) begin
               map[retire.arch_reg] <= '0;
            end
         end

         // new producer for dest
         if (rename_en) begin
            map[dispatch.dest].pending <= 1'b1;
            map[dispatch.dest].tag     <= dispatch.tag;
            map[dispatch.dest].ready   <= 1'b0;
         end
      end
   end

endmodule

//--- logic/station_bank.sv
`timescale 1ns/100ps

module station_bank (
   input  logic                                          clock,
   input  logic                                          reset,
   input  logic                                          dispatch_valid,
   input  rs_pkg::dispatch_t                             dispatch,
   input  rs_pkg::map_entry_t                            src1_state,
   input  rs_pkg::map_entry_t                            src2_state,
   input  rs_pkg::cdb_t                                  cdb,
   input  logic [rs_pkg::NUM_STATIONS-1:0]               exec_busy,
   output logic                                          dispatch_ready,
   output logic                                          accept,
   output logic [rs_pkg::NUM_STATIONS-1:0]               exec_run,
   output rs_pkg::issue_t [rs_pkg::NUM_STATIONS-1:0]     issue
);

   // station state, indexed by fu_kind_t
   rs_pkg::station_t stations [rs_pkg::NUM_STATIONS];

   // station picked for the current dispatch op
   rs_pkg::fu_kind_t target;

   //////////////////////////////////////////////////////////////////////
   // operand helpers
   //////////////////////////////////////////////////////////////////////

   // operand at dispatch time
   //   no producer or producer done -> dispatch value
   //   producer on the cdb this cycle -> cdb value
   //   else wait for the tag
   function automatic rs_pkg::operand_t capture(
      rs_pkg::map_entry_t            state,
      logic [rs_pkg::XLEN-1:0]       dispatch_value,
      rs_pkg::cdb_t                  bus
   );
      rs_pkg::operand_t opnd;
      opnd.wait_tag = state.tag;
      opnd.ready    = 1'b1;
      opnd.value    = dispatch_value;
      if (state.pending && !state.ready) begin
         if (bus.valid && (bus.tag == state.tag)) begin
            opnd.value = bus.value;
         end else begin
            opnd.ready = 1'b0;
         end
      end
      return opnd;
   endfunction

   // cdb snoop on a held operand
   function automatic rs_pkg::operand_t wake(
      rs_pkg::operand_t opnd,
      rs_pkg::cdb_t     bus
   );
      rs_pkg::operand_t result;
      result = opnd;
      if (!opnd.ready && bus.valid && (bus.tag == opnd.wait_tag)) begin
         result.ready = 1'b1;
         result.value = bus.value;
      end
      return result;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // allocation
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      target = rs_pkg::FU_ALU;
      case (dispatch.op)
         rs_pkg::OP_ALU:    target = rs_pkg::FU_ALU;
         rs_pkg::OP_MEM:    target = rs_pkg::FU_LSU;
         rs_pkg::OP_BRANCH: target = rs_pkg::FU_BRANCH;
         // mul0 first, spill to mul1
         rs_pkg::OP_MUL: begin
            if (!stations[rs_pkg::FU_MUL0].occupied) begin
               target = rs_pkg::FU_MUL0;
            end else begin
               target = rs_pkg::FU_MUL1;
            end
         end
         default:           target = rs_pkg::FU_ALU;
      endcase
   end

   // free means empty in registered state, not issuing this cycle
   assign dispatch_ready = !stations[target].occupied;
   assign accept         = dispatch_valid && dispatch_ready;

   //////////////////////////////////////////////////////////////////////
   // issue select
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < rs_pkg::NUM_STATIONS; i++) begin
         exec_run[i] = stations[i].occupied &&
                       stations[i].opnd1.ready &&
                       stations[i].opnd2.ready &&
                       !exec_busy[i];
         issue[i].tag    = stations[i].tag;
         issue[i].value1 = stations[i].opnd1.value;
         issue[i].value2 = stations[i].opnd2.value;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // station update
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < rs_pkg::NUM_STATIONS; i++) begin
            stations[i].occupied <= 1'b0;
         end
      end else begin
         for (int i = 0; i < rs_pkg::NUM_STATIONS; i++) begin
            // keep listening even while the unit is busy
            stations[i].opnd1 <= wake(stations[i].opnd1, cdb);
            stations[i].opnd2 <= wake(stations[i].opnd2, cdb);
            // unit takes it on this edge
            if (exec_run[i]) begin
               stations[i].occupied <= 1'b0;
            end
         end

         // target is empty, so never collides with an issue above
         if (accept) begin
            stations[target].occupied <= 1'b1;
            stations[target].tag      <= dispatch.tag;
            stations[target].opnd1    <= capture(src1_state, dispatch.value1, cdb);
            stations[target].opnd2    <= capture(src2_state, dispatch.value2, cdb);
         end
      end
   end

endmodule

//--- logic/rs_top.sv
`timescale 1ns/100ps

module rs_top (
   input  logic                                          clock,
   input  logic                                          reset,
   input  logic                                          dispatch_valid,
   input  rs_pkg::dispatch_t                             dispatch,
   input  rs_pkg::cdb_t                                  cdb,
   input  rs_pkg::retire_t                               retire,
   input  logic [rs_pkg::NUM_STATIONS-1:0]               exec_busy,
   output logic                                          dispatch_ready,
   output logic [rs_pkg::NUM_STATIONS-1:0]               exec_run,
   output rs_pkg::issue_t [rs_pkg::NUM_STATIONS-1:0]     issue
);

   // map lookup for the dispatch sources
   rs_pkg::map_entry_t src1_state;
   rs_pkg::map_entry_t src2_state;

   // dispatch handshake done this edge
   logic accept;

   //////////////////////////////////////////////////////////////////////
   // rename map
   //////////////////////////////////////////////////////////////////////

   rename_map u_rename_map (
      .clock      (clock),
      .reset      (reset),
      .accept     (accept),
      .dispatch   (dispatch),
      .cdb        (cdb),
      .retire     (retire),
      .src1_state (src1_state),
      .src2_state (src2_state)
   );

   //////////////////////////////////////////////////////////////////////
   // stations
   //////////////////////////////////////////////////////////////////////

   station_bank u_station_bank (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch       (dispatch),
      .src1_state     (src1_state),
      .src2_state     (src2_state),
      .cdb            (cdb),
      .exec_busy      (exec_busy),
      .dispatch_ready (dispatch_ready),
      .accept         (accept),
      .exec_run       (exec_run),
      .issue          (issue)
   );

endmodule

//--- bench/rs_tb.sv
`timescale 1ns/100ps

module rs_tb;

   localparam int CLOCK_PERIOD = 100;
   localparam int RESET_CYCLES = 10;
   // no test runs longer than this
   localparam int TEST_CYCLES = 60;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * TEST_CYCLES + 20;

   logic clock;
   logic reset;
   logic dispatch_valid;
   rs_pkg::dispatch_t dispatch;
   rs_pkg::cdb_t cdb;
   rs_pkg::retire_t retire;
   logic [rs_pkg::NUM_STATIONS-1:0] exec_busy;
   logic dispatch_ready;
   logic [rs_pkg::NUM_STATIONS-1:0] exec_run;
   rs_pkg::issue_t [rs_pkg::NUM_STATIONS-1:0] issue;

   int errors = 0;
   int checks = 0;
   int tests = 0;
   int errors_at_start = 0;
   logic [15:0] lfsr = 16'd6983;
   logic [31:0] va, vb, vc;

   rs_top dut (.*);

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit
   task automatic draw_word(output logic [31:0] word);
      for (int b = 0; b < 32; b++) begin
         lfsr = lfsr_step(lfsr);
         word[b] = lfsr[0];
      end
   endtask

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] got);
      checks++;
      assert (got == expected) else begin
         errors++;
         $display("ERR %s expected %h got %h", name, expected, got);
      end
   endtask

   // drive one packet and hold it until ready
   // an optional cdb goes out on the same edges
   task automatic send(rs_pkg::op_kind_t op, logic [rs_pkg::TAG_W-1:0] tag,
                       logic [rs_pkg::REG_W-1:0] src1, logic [rs_pkg::REG_W-1:0] src2,
                       logic [rs_pkg::REG_W-1:0] dest, logic [31:0] v1, logic [31:0] v2,
                       rs_pkg::cdb_t bus);
      @(posedge clock);
      dispatch_valid <= 1'b1;
      dispatch <= '{op, tag, src1, src2, dest, v1, v2};
      cdb <= bus;
      @(negedge clock);
      while (!dispatch_ready) begin
         @(negedge clock);
      end
      // transfer on this edge
      @(posedge clock);
      dispatch_valid <= 1'b0;
      cdb <= '0;
   endtask

   // limit 0 means exec_run must be up at the first sample
   task automatic wait_issue(rs_pkg::fu_kind_t st, int limit, logic [rs_pkg::TAG_W-1:0] tag,
                             logic [31:0] v1, logic [31:0] v2);
      int waited;
      waited = 0;
      @(negedge clock);
      while (!exec_run[st] && waited < limit) begin
         waited++;
         @(negedge clock);
      end
      assert (exec_run[st]) else begin
         errors++;
         $display("station %0d did not issue within %0d cycles", st, limit + 1);
      end
      if (exec_run[st]) begin
         check_value("issue.tag", 32'(tag), 32'(issue[st].tag));
         check_value("issue.value1", v1, issue[st].value1);
         check_value("issue.value2", v2, issue[st].value2);
      end
   endtask

   task automatic hold_idle(rs_pkg::fu_kind_t st, int cycles);
      repeat (cycles) begin
         @(negedge clock);
         check_value("exec_run", 0, 32'(exec_run[st]));
      end
   endtask

   task automatic pulse_cdb(logic [rs_pkg::TAG_W-1:0] tag, logic [31:0] value);
      @(posedge clock);
      cdb <= '{1'b1, tag, value};
      @(posedge clock);
      cdb <= '0;
   endtask

   task automatic pulse_retire(logic [rs_pkg::REG_W-1:0] arch_reg, logic [rs_pkg::TAG_W-1:0] tag);
      @(posedge clock);
      retire <= '{1'b1, arch_reg, tag};
      @(posedge clock);
      retire <= '0;
   endtask

   task automatic end_test(string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errors_at_start) ? "pass" : "FAIL");
      errors_at_start = errors;
   endtask

   // a busy unit never takes an issue
   assert property (@(negedge clock) disable iff (reset) (exec_run & exec_busy) == '0)
      else begin
         errors++;
         $display("a station issued to a busy unit");
      end

   //////////////////////////////////////////////////////////////////////
   // clock, watchdog, tests
   //////////////////////////////////////////////////////////////////////

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial begin
      reset = 1'b1;
      dispatch_valid = 1'b0;
      dispatch = '0;
      cdb = '0;
      retire = '0;
      exec_busy = '0;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;

      // idle after reset and ready for every op
      for (int op = 0; op < 4; op++) begin
         @(posedge clock);
         dispatch.op <= rs_pkg::op_kind_t'(op);
         @(negedge clock);
         check_value("exec_run", 0, 32'(exec_run));
         check_value("dispatch_ready", 1, 32'(dispatch_ready));
      end
      end_test("reset state");

      // alu held by busy then issues once
      draw_word(va);
      draw_word(vb);
      draw_word(vc);
      @(posedge clock);
      exec_busy[rs_pkg::FU_ALU] <= 1'b1;
      send(rs_pkg::OP_ALU, 3'd1, 5'd1, 5'd2, 5'd3, va, vb, '0);
      hold_idle(rs_pkg::FU_ALU, 4);
      @(posedge clock);
      exec_busy[rs_pkg::FU_ALU] <= 1'b0;
      wait_issue(rs_pkg::FU_ALU, 0, 3'd1, va, vb);
      hold_idle(rs_pkg::FU_ALU, 1);
      end_test("alu busy hold");

      // producer of r5 with tag 2
      // consumer waits for the cdb
      send(rs_pkg::OP_ALU, 3'd2, 5'd0, 5'd0, 5'd5, va, vb, '0);
      wait_issue(rs_pkg::FU_ALU, 0, 3'd2, va, vb);
      send(rs_pkg::OP_BRANCH, 3'd3, 5'd5, 5'd0, 5'd6, vb, va, '0);
      hold_idle(rs_pkg::FU_BRANCH, 3);
      pulse_cdb(3'd2, vc);
      wait_issue(rs_pkg::FU_BRANCH, 0, 3'd3, vc, va);
      end_test("cdb wake-up");

      // third mul back-pressured while both mul units are busy
      @(posedge clock);
      exec_busy[rs_pkg::FU_MUL0] <= 1'b1;
      exec_busy[rs_pkg::FU_MUL1] <= 1'b1;
      send(rs_pkg::OP_MUL, 3'd5, 5'd0, 5'd0, 5'd0, va, vb, '0);
      send(rs_pkg::OP_MUL, 3'd6, 5'd0, 5'd0, 5'd0, vb, vc, '0);
      @(posedge clock);
      dispatch_valid <= 1'b1;
      dispatch <= '{rs_pkg::OP_MUL, 3'd7, 5'd0, 5'd0, 5'd0, vc, va};
      repeat (3) begin
         @(negedge clock);
         check_value("dispatch_ready", 0, 32'(dispatch_ready));
      end
      @(posedge clock);
      exec_busy[rs_pkg::FU_MUL0] <= 1'b0;
      wait_issue(rs_pkg::FU_MUL0, 0, 3'd5, va, vb);
      @(negedge clock);
      check_value("dispatch_ready", 1, 32'(dispatch_ready));
      @(posedge clock);
      dispatch_valid <= 1'b0;
      wait_issue(rs_pkg::FU_MUL0, 0, 3'd7, vc, va);
      @(posedge clock);
      exec_busy[rs_pkg::FU_MUL1] <= 1'b0;
      wait_issue(rs_pkg::FU_MUL1, 0, 3'd6, vb, vc);
      end_test("mul spill");

      // reader of r5 while it is pending but ready
      send(rs_pkg::OP_BRANCH, 3'd0, 5'd5, 5'd0, 5'd0, va, vb, '0);
      wait_issue(rs_pkg::FU_BRANCH, 0, 3'd0, va, vb);
      // new producer of r5 with tag 2 retires before any broadcast
      send(rs_pkg::OP_ALU, 3'd2, 5'd0, 5'd0, 5'd5, vb, va, '0);
      wait_issue(rs_pkg::FU_ALU, 0, 3'd2, vb, va);
      pulse_retire(5'd5, 3'd2);
      send(rs_pkg::OP_BRANCH, 3'd1, 5'd0, 5'd5, 5'd0, vc, va, '0);
      wait_issue(rs_pkg::FU_BRANCH, 0, 3'd1, vc, va);
      // younger producer of r5 that a stale retire must not clear
      send(rs_pkg::OP_ALU, 3'd4, 5'd0, 5'd0, 5'd5, vb, vc, '0);
      wait_issue(rs_pkg::FU_ALU, 0, 3'd4, vb, vc);
      pulse_retire(5'd5, 3'd2);
      send(rs_pkg::OP_MEM, 3'd2, 5'd5, 5'd0, 5'd0, va, vb, '0);
      hold_idle(rs_pkg::FU_LSU, 3);
      pulse_cdb(3'd4, vc);
      wait_issue(rs_pkg::FU_LSU, 0, 3'd2, vc, vb);
      end_test("map ready and retire");

      // cdb on the accepting edge
      send(rs_pkg::OP_ALU, 3'd5, 5'd0, 5'd0, 5'd9, va, vb, '0);
      wait_issue(rs_pkg::FU_ALU, 0, 3'd5, va, vb);
      send(rs_pkg::OP_MEM, 3'd6, 5'd0, 5'd9, 5'd0, vb, va, '{1'b1, 3'd5, vc});
      wait_issue(rs_pkg::FU_LSU, 0, 3'd6, vb, vc);
      end_test("same-cycle capture");

      $display("tests %0d checks %0d errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- list.f
logic/rs_pkg.sv
logic/rename_map.sv
logic/station_bank.sv
logic/rs_top.sv
bench/rs_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rs_tb -f list.f -o Vrs_tb

./obj_dir/Vrs_tb > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
   exit 1
fi
exit 0
